// File: src/isa_pkg.sv
// Only the RV32 groups the front end classifies are named; other opcodes decode as illegal
`default_nettype none

package isa_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Data and instruction width
    localparam int xlen = 32;
    // Architected register index
    localparam int reg_idx_w = 5;

    ////////////////////
    // Encodings
    ////////////////////

    // RISC-V major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // M extension marker inside OP
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // WFI, used as the halt word
    localparam logic [xlen-1:0] inst_wfi = 32'h1050_0073;

    ////////////////////
    // Operation classes
    ////////////////////

    localparam int op_class_w = 3;

    localparam logic [op_class_w-1:0] cls_alu     = 3'd0;
    localparam logic [op_class_w-1:0] cls_mult    = 3'd1;
    localparam logic [op_class_w-1:0] cls_branch  = 3'd2;
    localparam logic [op_class_w-1:0] cls_mem     = 3'd3;
    localparam logic [op_class_w-1:0] cls_halt    = 3'd4;
    localparam logic [op_class_w-1:0] cls_illegal = 3'd7;

    // Same 32 bits seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } i;
    } inst_word_u;

endpackage

`default_nettype wire

// File: src/frontend_pkg.sv
// Sizes are fixed; pointer and count widths must be edited together with the depths they cover
`default_nettype none

package frontend_pkg;

    ////////////////////
    // Bundle and dispatch
    ////////////////////

    // Words gathered per buffer push
    localparam int bundle_w = 4;
    // Words decoded per cycle at most
    localparam int disp_w = 3;
    // Dispatch and slot counts, 0..3
    localparam int disp_cnt_w = 2;

    ////////////////////
    // Instruction buffer
    ////////////////////

    localparam int ib_depth = 8;
    // log2 of ib_depth
    localparam int ib_ptr_w = 3;
    // Occupancy 0..ib_depth
    localparam int ib_cnt_w = 4;

    ////////////////////
    // Program counter
    ////////////////////

    // Byte step per 32-bit word
    localparam logic [isa_pkg::xlen-1:0] pc_step = 4;
    localparam logic [isa_pkg::xlen-1:0] reset_pc = '0;

endpackage

`default_nettype wire

// File: src/fetch_bundler.sv
// Accepts one word per strobe; a partial bundle stays held until its fourth word or a flush
`timescale 1ns/1ps
`default_nettype none

module fetch_bundler (
    input  wire logic                                                   clock,
    input  wire logic                                                   arst_n,
    input  wire logic                                                   inst_valid,
    input  wire logic [isa_pkg::xlen-1:0]                               inst,
    input  wire logic                                                   flush,
    input  wire logic [isa_pkg::xlen-1:0]                               pc_override,
    input  wire logic                                                   ib_full,
    output logic                                                        inst_ready,
    output logic                                                        ib_push,
    output logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]        bundle_inst,
    output logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]        bundle_pc
);

    // Fetch PC of the next accepted word
    logic [isa_pkg::xlen-1:0] pc;
    // Words waiting for the rest of their bundle
    logic [$clog2(frontend_pkg::bundle_w)-1:0] held_cnt;
    logic [isa_pkg::xlen-1:0] held_inst [frontend_pkg::bundle_w-1];
    logic [isa_pkg::xlen-1:0] held_pc   [frontend_pkg::bundle_w-1];

    logic accept;
    logic last_word;

    // Stall only when this word would complete a bundle with no room
    assign last_word  = (held_cnt == frontend_pkg::bundle_w - 1);
    assign inst_ready = !(last_word && ib_full);

    // Flush wins over an accept on the same edge
    assign accept  = inst_valid && inst_ready && !flush;
    assign ib_push = accept && last_word;

    ////////////////////
    // Bundle assembly
    ////////////////////

    always_comb begin
        // Held words are the oldest lanes
        for (int i = 0; i < frontend_pkg::bundle_w - 1; i++) begin
            bundle_inst[i] = held_inst[i];
            bundle_pc[i]   = held_pc[i];
        end
        // Incoming word closes the bundle
        bundle_inst[frontend_pkg::bundle_w-1] = inst;
        bundle_pc[frontend_pkg::bundle_w-1]   = pc;
    end

    ////////////////////
    // PC and fill count
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= frontend_pkg::reset_pc;
            held_cnt <= '0;
        end else if (flush) begin
            // Redirect and drop the partial bundle
            pc       <= pc_override;
            held_cnt <= '0;
        end else if (accept) begin
            pc       <= pc + frontend_pkg::pc_step;
            held_cnt <= ib_push ? '0 : held_cnt + 1'b1;
        end
    end

    // Word store, slot picked by the fill count
    always_ff @(posedge clock) begin
        if (accept && !last_word) begin
            held_inst[held_cnt] <= inst;
            held_pc[held_cnt]   <= pc;
        end
    end

endmodule

`default_nettype wire

// File: src/instr_buffer.sv
// Push is always a full bundle; caller must keep disp_count within win_count and push off when full
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
    input  wire logic                                                   clock,
    input  wire logic                                                   arst_n,
    input  wire logic                                                   flush,
    input  wire logic                                                   ib_push,
    input  wire logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]   bundle_inst,
    input  wire logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]   bundle_pc,
    input  wire logic [frontend_pkg::disp_cnt_w-1:0]                    disp_count,
    output logic                                                        ib_full,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]          win_inst,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]          win_pc,
    output logic [frontend_pkg::disp_cnt_w-1:0]                         win_count
);

    ////////////////////
    // Storage
    ////////////////////

    // Word and its PC side by side
    logic [isa_pkg::xlen-1:0] mem_inst [frontend_pkg::ib_depth];
    logic [isa_pkg::xlen-1:0] mem_pc   [frontend_pkg::ib_depth];

    // Head is the oldest entry, tail the next free one
    logic [frontend_pkg::ib_ptr_w-1:0] head;
    logic [frontend_pkg::ib_ptr_w-1:0] tail;
    logic [frontend_pkg::ib_cnt_w-1:0] occ;

    // Entries added and removed this cycle
    logic [frontend_pkg::ib_cnt_w-1:0] push_n;
    logic [frontend_pkg::ib_cnt_w-1:0] pop_n;

    assign push_n = ib_push ? (frontend_pkg::ib_cnt_w)'(frontend_pkg::bundle_w) : '0;
    assign pop_n  = (frontend_pkg::ib_cnt_w)'(disp_count);

    // Full once a whole bundle no longer fits
    assign ib_full = (occ > frontend_pkg::ib_depth - frontend_pkg::bundle_w);

    ////////////////////
    // Dispatch window
    ////////////////////

    // Capped at the dispatch width
    assign win_count = (occ >= frontend_pkg::disp_w) ?
                       (frontend_pkg::disp_cnt_w)'(frontend_pkg::disp_w) :
                       occ[frontend_pkg::disp_cnt_w-1:0];

    // Oldest entries from head, wrapping on the pointer width
    for (genvar i = 0; i < frontend_pkg::disp_w; i++) begin : g_win
        assign win_inst[i] = mem_inst[head + (frontend_pkg::ib_ptr_w)'(i)];
        assign win_pc[i]   = mem_pc[head + (frontend_pkg::ib_ptr_w)'(i)];
    end

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else if (flush) begin
            // Mispredict drops every stored word
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            if (ib_push) begin
                tail <= tail + (frontend_pkg::ib_ptr_w)'(frontend_pkg::bundle_w);
            end
            // Pop and push may share an edge
            head <= head + (frontend_pkg::ib_ptr_w)'(disp_count);
            occ  <= occ + push_n - pop_n;
        end
    end

    // Four consecutive slots from tail
    always_ff @(posedge clock) begin
        if (ib_push && !flush) begin
            for (int i = 0; i < frontend_pkg::bundle_w; i++) begin
                mem_inst[tail + (frontend_pkg::ib_ptr_w)'(i)] <= bundle_inst[i];
                mem_pc[tail + (frontend_pkg::ib_ptr_w)'(i)]   <= bundle_pc[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dispatch_decode.sv
// Lane fields beyond disp_valid hold stale data; only classes, indices and I-type immediates decode
`timescale 1ns/1ps
`default_nettype none

module dispatch_decode (
    input  wire logic                                                 clock,
    input  wire logic                                                 arst_n,
    input  wire logic                                                 flush,
    input  wire logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]   win_inst,
    input  wire logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]   win_pc,
    input  wire logic [frontend_pkg::disp_cnt_w-1:0]                  win_count,
    input  wire logic [frontend_pkg::disp_cnt_w-1:0]                  be_free_slots,
    output logic [frontend_pkg::disp_cnt_w-1:0]                       disp_count,
    output logic [frontend_pkg::disp_w-1:0]                           disp_valid,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]        disp_pc,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::op_class_w-1:0]  disp_class,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rd,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rs1,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rs2,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]        disp_imm
);

    // Window words seen through the R and I views
    isa_pkg::inst_word_u [frontend_pkg::disp_w-1:0] word;

    // Next-state lane fields
    logic [frontend_pkg::disp_w-1:0]                          valid_d;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::op_class_w-1:0] class_d;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  rd_d;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  rs1_d;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  rs2_d;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]       imm_d;

    assign word = win_inst;

    // Pop no more than the back end can take
    assign disp_count = (win_count < be_free_slots) ? win_count : be_free_slots;

    ////////////////////
    // Lane decode
    ////////////////////

    always_comb begin
        for (int i = 0; i < frontend_pkg::disp_w; i++) begin
            valid_d[i] = (i < disp_count);
            // Raw register fields unless a rule clears them
            rd_d[i]    = word[i].r.rd;
            rs1_d[i]   = word[i].r.rs1;
            rs2_d[i]   = word[i].r.rs2;
            imm_d[i]   = '0;
            class_d[i] = isa_pkg::cls_illegal;
            case (word[i].r.opcode)
                isa_pkg::opc_op: begin
                    // M extension goes to the multiplier
                    class_d[i] = (word[i].r.funct7 == isa_pkg::funct7_muldiv) ?
                                 isa_pkg::cls_mult : isa_pkg::cls_alu;
                end
                isa_pkg::opc_op_imm, isa_pkg::opc_load: begin
                    class_d[i] = (word[i].r.opcode == isa_pkg::opc_load) ?
                                 isa_pkg::cls_mem : isa_pkg::cls_alu;
                    // I-type, no second source
                    rs2_d[i]   = '0;
                    imm_d[i]   = {{(isa_pkg::xlen-12){word[i].i.imm[11]}}, word[i].i.imm};
                end
                isa_pkg::opc_store: begin
                    class_d[i] = isa_pkg::cls_mem;
                    rd_d[i]    = '0;
                end
                isa_pkg::opc_branch: begin
                    class_d[i] = isa_pkg::cls_branch;
                    rd_d[i]    = '0;
                end
                default: begin
                    // WFI ends the program; any other opcode is illegal
                    if (word[i] == isa_pkg::inst_wfi) begin
                        class_d[i] = isa_pkg::cls_halt;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Dispatch registers
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            disp_valid <= '0;
        end else if (flush) begin
            disp_valid <= '0;
        end else begin
            disp_valid <= valid_d;
        end
    end

    // Payload follows the window every cycle
    always_ff @(posedge clock) begin
        disp_pc    <= win_pc;
        disp_class <= class_d;
        disp_rd    <= rd_d;
        disp_rs1   <= rs1_d;
        disp_rs2   <= rs2_d;
        disp_imm   <= imm_d;
    end

endmodule

`default_nettype wire

// File: src/frontend_top.sv
// Front end only; flush and pc_override come from an external resolve stage as a one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire logic                                                 clock,
    input  wire logic                                                 arst_n,
    input  wire logic                                                 inst_valid,
    input  wire logic [isa_pkg::xlen-1:0]                             inst,
    input  wire logic [frontend_pkg::disp_cnt_w-1:0]                  be_free_slots,
    input  wire logic                                                 flush,
    input  wire logic [isa_pkg::xlen-1:0]                             pc_override,
    output logic                                                      inst_ready,
    output logic [frontend_pkg::disp_w-1:0]                           disp_valid,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]        disp_pc,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::op_class_w-1:0]  disp_class,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rd,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rs1,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]   disp_rs2,
    output logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]        disp_imm
);

    ////////////////////
    // Fetch to buffer
    ////////////////////

    logic                                                   ib_push;
    logic                                                   ib_full;
    logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]   bundle_inst;
    logic [frontend_pkg::bundle_w-1:0][isa_pkg::xlen-1:0]   bundle_pc;

    // Buffer to decoder
    logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]     win_inst;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]     win_pc;
    logic [frontend_pkg::disp_cnt_w-1:0]                    win_count;
    logic [frontend_pkg::disp_cnt_w-1:0]                    disp_count;

    fetch_bundler u_bundler (
        .clock       (clock),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .flush       (flush),
        .pc_override (pc_override),
        .ib_full     (ib_full),
        .inst_ready  (inst_ready),
        .ib_push     (ib_push),
        .bundle_inst (bundle_inst),
        .bundle_pc   (bundle_pc)
    );

    instr_buffer u_ibuf (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .ib_push     (ib_push),
        .bundle_inst (bundle_inst),
        .bundle_pc   (bundle_pc),
        .disp_count  (disp_count),
        .ib_full     (ib_full),
        .win_inst    (win_inst),
        .win_pc      (win_pc),
        .win_count   (win_count)
    );

    // Pop count loops back from the decoder
    dispatch_decode u_decode (
        .clock         (clock),
        .arst_n        (arst_n),
        .flush         (flush),
        .win_inst      (win_inst),
        .win_pc        (win_pc),
        .win_count     (win_count),
        .be_free_slots (be_free_slots),
        .disp_count    (disp_count),
        .disp_valid    (disp_valid),
        .disp_pc       (disp_pc),
        .disp_class    (disp_class),
        .disp_rd       (disp_rd),
        .disp_rs1      (disp_rs1),
        .disp_rs2      (disp_rs2),
        .disp_imm      (disp_imm)
    );

endmodule

`default_nettype wire

// File: sim/frontend_sva.sv
// Buffer checks only; needs a simulator with concurrent assertions enabled, counts failures
`timescale 1ns/1ps
`default_nettype none

module frontend_sva (
    input wire logic                                  clock,
    input wire logic                                  arst_n,
    input wire logic [frontend_pkg::ib_cnt_w-1:0]     occ,
    input wire logic                                  ib_push,
    input wire logic                                  ib_full,
    input wire logic [frontend_pkg::disp_cnt_w-1:0]   disp_count,
    input wire logic [frontend_pkg::disp_cnt_w-1:0]   win_count
);

    // Failures seen so far, read by the testbench
    int fail_cnt;

    initial fail_cnt = 0;

    ////////////////////
    // Buffer rules
    ////////////////////

    // Occupancy bounded by the store
    a_occ_bound: assert property (@(posedge clock) disable iff (!arst_n)
        occ <= frontend_pkg::ib_depth)
        else begin
            $error("instruction buffer occupancy above its depth");
            fail_cnt++;
        end

    // Bundle never pushed into a full buffer
    a_push_full: assert property (@(posedge clock) disable iff (!arst_n)
        !(ib_push && ib_full))
        else begin
            $error("bundle pushed while the buffer was full");
            fail_cnt++;
        end

    // Pop limited to the window
    a_pop_window: assert property (@(posedge clock) disable iff (!arst_n)
        disp_count <= win_count)
        else begin
            $error("pop count larger than the dispatch window");
            fail_cnt++;
        end

endmodule

bind instr_buffer frontend_sva u_sva (
    .clock      (clock),
    .arst_n     (arst_n),
    .occ        (occ),
    .ib_push    (ib_push),
    .ib_full    (ib_full),
    .disp_count (disp_count),
    .win_count  (win_count)
);

`default_nettype wire

// File: sim/frontend_tb.sv
// Tests leave a partial bundle only ahead of a flush; dispatch lanes are sampled at the falling edge
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    logic                                                 clock;
    logic                                                 arst_n;
    logic                                                 inst_valid;
    logic [isa_pkg::xlen-1:0]                             inst;
    logic [frontend_pkg::disp_cnt_w-1:0]                  be_free_slots;
    logic                                                 flush;
    logic [isa_pkg::xlen-1:0]                             pc_override;
    logic                                                 inst_ready;
    logic [frontend_pkg::disp_w-1:0]                      disp_valid;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]   disp_pc;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::op_class_w-1:0] disp_class;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  disp_rd;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  disp_rs1;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::reg_idx_w-1:0]  disp_rs2;
    logic [frontend_pkg::disp_w-1:0][isa_pkg::xlen-1:0]   disp_imm;

    // Expected dispatch stream in age order
    logic [isa_pkg::xlen-1:0]       exp_pc[$];
    logic [isa_pkg::op_class_w-1:0] exp_class[$];
    logic [isa_pkg::reg_idx_w-1:0]  exp_rd[$];
    logic [isa_pkg::reg_idx_w-1:0]  exp_rs1[$];
    logic [isa_pkg::reg_idx_w-1:0]  exp_rs2[$];
    logic [isa_pkg::xlen-1:0]       exp_imm[$];

    logic [isa_pkg::xlen-1:0] model_pc;
    logic [15:0]              lfsr_state;
    string                    cur_test;
    int                       err_value;
    int                       err_other;

    frontend_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input string name, input logic [isa_pkg::xlen-1:0] exp,
                              input logic [isa_pkg::xlen-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input logic [isa_pkg::op_class_w-1:0] exp,
                               input logic [isa_pkg::op_class_w-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [isa_pkg::reg_idx_w-1:0] exp,
                             input logic [isa_pkg::reg_idx_w-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("FAIL %s expected x%0d actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_valid(input string name, input logic [frontend_pkg::disp_w-1:0] exp,
                               input logic [frontend_pkg::disp_w-1:0] act);
        if (act !== exp) begin
            err_value++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic clear_model();
        exp_pc.delete();
        exp_class.delete();
        exp_rd.delete();
        exp_rs1.delete();
        exp_rs2.delete();
        exp_imm.delete();
    endtask

    // Hold the strobe until the word is taken and log its expected dispatch
    task automatic send_word(input isa_pkg::inst_word_u w,
                             input logic [isa_pkg::op_class_w-1:0] cls,
                             input logic [isa_pkg::reg_idx_w-1:0] rd,
                             input logic [isa_pkg::reg_idx_w-1:0] rs1,
                             input logic [isa_pkg::reg_idx_w-1:0] rs2,
                             input logic [isa_pkg::xlen-1:0] imm);
        int  t;
        logic got;
        t = 0;
        got = 1'b0;
        inst = w;
        inst_valid = 1'b1;
        while (!got && t < 200) begin
            @(negedge clock);
            got = inst_ready;
            next_cycle();
            t++;
        end
        inst_valid = 1'b0;
        if (got) begin
            exp_pc.push_back(model_pc);
            exp_class.push_back(cls);
            exp_rd.push_back(rd);
            exp_rs1.push_back(rs1);
            exp_rs2.push_back(rs2);
            exp_imm.push_back(imm);
            model_pc = model_pc + 32'd4;
        end else begin
            err_other++;
            $display("%s: word %h was never accepted", cur_test, w);
        end
    endtask

    // Kind codes 0 alu 1 mult 2 op-imm 3 load 4 store 5 branch 6 halt 7 illegal
    task automatic send_kind(input int kind);
        isa_pkg::inst_word_u            w;
        logic [isa_pkg::op_class_w-1:0] cls;
        logic [isa_pkg::reg_idx_w-1:0]  rd;
        logic [isa_pkg::reg_idx_w-1:0]  rs2;
        logic [isa_pkg::xlen-1:0]       imm;
        w = rand_bits(32);
        imm = '0;
        case (kind)
            0: begin
                w.r.opcode = 7'b0110011;
                // Bit 0 clear keeps it off the multiply marker
                w.r.funct7[0] = 1'b0;
                cls = 3'd0;
            end
            1: begin
                w.r.opcode = 7'b0110011;
                w.r.funct7 = 7'b0000001;
                cls = 3'd1;
            end
            2: begin
                w.r.opcode = 7'b0010011;
                cls = 3'd0;
            end
            3: begin
                w.r.opcode = 7'b0000011;
                cls = 3'd3;
            end
            4: begin
                w.r.opcode = 7'b0100011;
                cls = 3'd3;
            end
            5: begin
                w.r.opcode = 7'b1100011;
                cls = 3'd2;
            end
            6: begin
                // WFI
                w = 32'h1050_0073;
                cls = 3'd4;
            end
            default: begin
                w.r.opcode = 7'b1111111;
                cls = 3'd7;
            end
        endcase
        rd  = w.r.rd;
        rs2 = w.r.rs2;
        // I-type drops rs2 and carries a signed immediate
        if (kind == 2 || kind == 3) begin
            rs2 = '0;
            imm = 32'($signed(w.i.imm));
        end
        // Store and branch write no register
        if (kind == 4 || kind == 5) begin
            rd = '0;
        end
        send_word(w, cls, rd, w.r.rs1, rs2, imm);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_pc.size() != 0 && t < 200) begin
            next_cycle();
            t++;
        end
        if (exp_pc.size() != 0) begin
            err_other++;
            $display("%s: %0d words were never dispatched", cur_test, exp_pc.size());
            clear_model();
        end
    endtask

    ////////////////////
    // Dispatch monitor
    ////////////////////

    // Lanes are read once the outputs have settled
    initial begin
        logic [frontend_pkg::disp_cnt_w-1:0] last_slots;
        last_slots = '0;
        forever begin
            @(negedge clock);
            if (arst_n) begin
                if ($countones(disp_valid) > last_slots) begin
                    err_other++;
                    $display("%s: %0d lanes dispatched with only %0d back-end slots",
                             cur_test, $countones(disp_valid), last_slots);
                end
                for (int i = 0; i < frontend_pkg::disp_w; i++) begin
                    if (disp_valid[i] === 1'b1 && exp_pc.size() == 0) begin
                        err_other++;
                        $display("%s: unexpected dispatch at pc %h", cur_test, disp_pc[i]);
                    end else if (disp_valid[i] === 1'b1) begin
                        check_word($sformatf("%s lane%0d pc", cur_test, i),
                                   exp_pc.pop_front(), disp_pc[i]);
                        check_class($sformatf("%s lane%0d class", cur_test, i),
                                    exp_class.pop_front(), disp_class[i]);
                        check_reg($sformatf("%s lane%0d rd", cur_test, i),
                                  exp_rd.pop_front(), disp_rd[i]);
                        check_reg($sformatf("%s lane%0d rs1", cur_test, i),
                                  exp_rs1.pop_front(), disp_rs1[i]);
                        check_reg($sformatf("%s lane%0d rs2", cur_test, i),
                                  exp_rs2.pop_front(), disp_rs2[i]);
                        check_word($sformatf("%s lane%0d imm", cur_test, i),
                                   exp_imm.pop_front(), disp_imm[i]);
                    end
                end
            end
            // Slot level that the next rising edge will use
            last_slots = be_free_slots;
        end
    end

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset();
        cur_test = "reset";
        @(negedge clock);
        check_valid("reset disp_valid", 3'b000, disp_valid);
        check_flag("reset inst_ready", 1'b1, inst_ready);
        next_cycle();
        be_free_slots = 2'd3;
        // First dispatched PC must be zero
        for (int n = 0; n < 4; n++) begin
            send_kind(2);
        end
        wait_drain();
    endtask

    task automatic test_all_kinds();
        cur_test = "all_kinds";
        be_free_slots = 2'd3;
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 8; n++) begin
                send_kind(k);
            end
        end
        wait_drain();
    endtask

    task automatic test_slot_limit();
        cur_test = "slot_limit";
        be_free_slots = 2'd1;
        for (int n = 0; n < 8; n++) begin
            send_kind(n % 6);
        end
        wait_drain();
        // With no slots the words must stay queued
        be_free_slots = 2'd0;
        for (int n = 0; n < 8; n++) begin
            send_kind(n % 6);
        end
        repeat (10) next_cycle();
        be_free_slots = 2'd3;
        wait_drain();
    endtask

    task automatic test_backpressure();
        cur_test = "backpressure";
        be_free_slots = 2'd0;
        // Eight in the buffer and three held in the bundler
        for (int n = 0; n < 11; n++) begin
            send_kind(n % 6);
        end
        @(negedge clock);
        check_flag("backpressure inst_ready", 1'b0, inst_ready);
        next_cycle();
        be_free_slots = 2'd2;
        send_kind(5);
        wait_drain();
    endtask

    task automatic test_flush();
        cur_test = "flush";
        be_free_slots = 2'd0;
        // Full buffer plus three held words
        for (int n = 0; n < 11; n++) begin
            send_kind(n % 6);
        end
        @(negedge clock);
        check_flag("flush stalled inst_ready", 1'b0, inst_ready);
        next_cycle();
        be_free_slots = 2'd3;
        next_cycle();
        // Three lanes are on the outputs while the flush is applied
        flush = 1'b1;
        pc_override = 32'h0000_0200;
        next_cycle();
        flush = 1'b0;
        clear_model();
        model_pc = 32'h0000_0200;
        @(negedge clock);
        check_valid("flush disp_valid", 3'b000, disp_valid);
        check_flag("flush inst_ready", 1'b1, inst_ready);
        next_cycle();
        for (int n = 0; n < 8; n++) begin
            send_kind(n % 6);
        end
        wait_drain();
    endtask

    task automatic test_halt_illegal();
        cur_test = "halt_illegal";
        be_free_slots = 2'd3;
        for (int n = 0; n < 4; n++) begin
            send_kind(6 + (n % 2));
        end
        wait_drain();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int sva_errors;
        arst_n        = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        be_free_slots = '0;
        flush         = 1'b0;
        pc_override   = '0;
        lfsr_state    = 16'd20;
        model_pc      = '0;
        err_value     = 0;
        err_other     = 0;
        cur_test      = "init";
        repeat (4) @(posedge clock);
        #2;
        arst_n = 1'b1;

        test_reset();
        test_all_kinds();
        test_slot_limit();
        test_backpressure();
        test_flush();
        test_halt_illegal();
        repeat (2) next_cycle();

        sva_errors = u_dut.u_ibuf.u_sva.fail_cnt;
        $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
                 err_value, err_other, sva_errors);
        if (err_value == 0 && err_other == 0 && sva_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Backstop far beyond the longest test
    initial begin
        #1_000_000;
        $display("simulation watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/isa_pkg.sv
src/frontend_pkg.sv
src/fetch_bundler.sv
src/instr_buffer.sv
src/dispatch_decode.sv
src/frontend_top.sv
sim/frontend_sva.sv
sim/frontend_tb.sv
